/* flist.f */
mac_tx_pkg.sv
frame_if.sv
frame_assembler.sv
frame_buffer.sv
crc8_gen.sv
xmit_controller.sv
mac_tx_top.sv
mac_tx_assert.sv
tb_mac_tx.sv

/* run.sh */
#!/bin/sh
# compile with Verilator and run, exit status gives pass or fail
verilator --binary --assert --top-module tb_mac_tx -f flist.f -o tb_mac_tx \
    && ./obj_dir/tb_mac_tx \
    || exit 1

/* tb_mac_tx.sv */
`timescale 1ns/10ps

module tb_mac_tx;
    import mac_tx_pkg::*;

    localparam int          PREAMBLE_LENGTH = 2;
    localparam byte_t       STATION_ADDR    = 8'h4a;
    localparam int          MAX_PAYLOAD     = 255;
    localparam int          MAX_ATTEMPTS    = 3;
    localparam int          NUM_ROWS        = 7;
    localparam int          HOST_TIMEOUT    = 200;
    localparam int          BUSY_TIMEOUT    = 1000;
    localparam int          LINE_TIMEOUT    = 3000;
    localparam int          CARDET_CLOCKS   = 30;
    // carrier comes up halfway through DIFS
    localparam int          CARDET_DELAY    = 16;
    localparam logic [31:0] SEED            = 32'hf0ae3732;

    typedef enum logic [1:0] {ACK_NONE, ACK_FIRST, ACK_NEVER} ack_mode_t;

    typedef struct packed {
        ftype_t     ftype;
        byte_t      dest;
        logic [8:0] pay_len;
        ack_mode_t  ack_mode;
        logic       busy_start;
    } row_t;

    logic  clk = 1'b0;
    logic  rst;
    byte_t xdata;
    logic  xvalid;
    logic  xsend;
    logic  xrdy;
    logic  tick = 1'b0;
    logic  cardet = 1'b0;
    logic  ack_received;
    byte_t mx_data;
    logic  mx_valid;
    logic  mx_rdy = 1'b0;
    logic  xbusy;
    byte_t xerrcnt;

    row_t        rows [NUM_ROWS];
    byte_t       line_q [$];
    logic [31:0] pay_rng;
    logic [31:0] rdy_rng = SEED;
    byte_t       exp_errcnt;
    int          cyc = 0;
    int          cardet_until = 0;

    mac_tx_top #(
        .PREAMBLE_LENGTH (PREAMBLE_LENGTH),
        .MAC_ADDR        (STATION_ADDR),
        .MAX_PAYLOAD     (MAX_PAYLOAD),
        .MAX_ATTEMPTS    (MAX_ATTEMPTS)
    ) mac_tx_top_i (
        .clk          (clk),
        .rst          (rst),
        .xdata        (xdata),
        .xvalid       (xvalid),
        .xsend        (xsend),
        .xrdy         (xrdy),
        .tick         (tick),
        .cardet       (cardet),
        .ack_received (ack_received),
        .mx_data      (mx_data),
        .mx_valid     (mx_valid),
        .mx_rdy       (mx_rdy),
        .xbusy        (xbusy),
        .xerrcnt      (xerrcnt)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // CRC-8 poly 07, one bit at a time, msb first
    function automatic byte_t crc_step(input byte_t crc_in, input byte_t value);
        byte_t c;
        logic  fb;
        c = crc_in;
        for (int i = 7; i >= 0; i--) begin
            fb = c[7] ^ value[i];
            c = {c[6:0], 1'b0};
            if (fb) c = c ^ 8'h07;
        end
        return c;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    // tick every 4 clocks, random mx_rdy, cardet window
    always @(posedge clk) begin
        #1;
        cyc++;
        rdy_rng = xorshift(rdy_rng);
        mx_rdy = (rdy_rng[1:0] != 2'b00);
        tick = (cyc % 4 == 0);
        cardet = (cyc <= cardet_until);
    end

    // bytes seen here move on the next rising edge
    always @(negedge clk) begin
        if (!rst && mx_valid && mx_rdy) begin
            check_value("cardet at line transfer", 32'(cardet), 32'd0);
            line_q.push_back(mx_data);
        end
    end

    task automatic put_byte(input byte_t value, input logic last);
        int   waited;
        logic taken;
        waited = 0;
        taken = 1'b0;
        xdata = value;
        xvalid = 1'b1;
        xsend = last;
        while (!taken) begin
            @(negedge clk);
            taken = xrdy;
            @(posedge clk);
            #1;
            waited++;
            if (!taken && waited > HOST_TIMEOUT) begin
                abort_run($sformatf("host byte %02h was never taken, time %0t", value, $time));
            end
        end
        xvalid = 1'b0;
        xsend = 1'b0;
    endtask

    task automatic wait_busy(input logic level);
        int   waited;
        logic done;
        waited = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = (xbusy == level);
            @(posedge clk);
            #1;
            waited++;
            if (!done && waited > BUSY_TIMEOUT) begin
                abort_run($sformatf("xbusy never went to %0b, time %0t", level, $time));
            end
        end
    endtask

    task automatic wait_bytes(input int count);
        int waited;
        waited = 0;
        while (line_q.size() < count) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > LINE_TIMEOUT) begin
                abort_run($sformatf("a frame of %0d bytes was not sent on the line, time %0t",
                                    count, $time));
            end
        end
    endtask

    task automatic pulse_ack();
        @(posedge clk);
        #1;
        ack_received = 1'b1;
        @(posedge clk);
        #1;
        ack_received = 1'b0;
    endtask

    task automatic run_row(input row_t row);
        byte_t payload [$];
        byte_t expected [$];
        byte_t crc;
        byte_t got;
        int    sends;
        logic  use_xsend;
        for (int i = 0; i < int'(row.pay_len); i++) begin
            pay_rng = xorshift(pay_rng);
            payload.push_back(pay_rng[7:0]);
        end
        // reference frame as it should appear on the line
        for (int i = 0; i < PREAMBLE_LENGTH; i++) expected.push_back(PREAMBLE_BYTE);
        expected.push_back(SFD_BYTE);
        expected.push_back(row.dest);
        expected.push_back(STATION_ADDR);
        expected.push_back(row.ftype);
        foreach (payload[i]) expected.push_back(payload[i]);
        crc = '0;
        for (int i = PREAMBLE_LENGTH + 1; i < expected.size(); i++) begin
            crc = crc_step(crc, expected[i]);
        end
        if (row.ftype != FTYPE_RAW) expected.push_back(crc);

        // a full-size payload is cut by length and gets no xsend
        use_xsend = (int'(row.pay_len) != MAX_PAYLOAD);
        put_byte(row.dest, 1'b0);
        put_byte(row.ftype, 1'b0);
        foreach (payload[i]) put_byte(payload[i], use_xsend && (i == payload.size() - 1));
        wait_busy(1'b1);
        if (row.busy_start) begin
            repeat (CARDET_DELAY) @(posedge clk);
            @(negedge clk);
            cardet_until = cyc + CARDET_CLOCKS;
        end

        sends = (row.ack_mode == ACK_NEVER) ? MAX_ATTEMPTS : 1;
        for (int s = 0; s < sends; s++) begin
            wait_bytes(expected.size());
            for (int i = 0; i < expected.size(); i++) begin
                got = line_q.pop_front();
                check_value($sformatf("mx_data byte %0d of send %0d", i, s),
                            32'(got), 32'(expected[i]));
            end
            if (row.ack_mode == ACK_FIRST) pulse_ack();
        end
        wait_busy(1'b0);
        check_value("line bytes after release", 32'(line_q.size()), 32'd0);
        if (row.ack_mode == ACK_NEVER) exp_errcnt = exp_errcnt + 8'd1;
        check_value("xerrcnt", 32'(xerrcnt), 32'(exp_errcnt));
    endtask

    initial begin
        rst = 1'b1;
        xdata = '0;
        xvalid = 1'b0;
        xsend = 1'b0;
        ack_received = 1'b0;
        pay_rng = SEED;
        exp_errcnt = '0;
        rows[0] = '{FTYPE_DATA, 8'h12, 9'd16, ACK_NONE, 1'b0};
        rows[1] = '{FTYPE_RAW, 8'h23, 9'd9, ACK_NONE, 1'b0};
        rows[2] = '{FTYPE_ACKREQ, 8'h34, 9'd12, ACK_FIRST, 1'b0};
        rows[3] = '{FTYPE_ACKREQ, 8'h45, 9'd7, ACK_NEVER, 1'b0};
        rows[4] = '{FTYPE_DATA, 8'h56, 9'd4, ACK_NONE, 1'b1};
        rows[5] = '{FTYPE_DATA, 8'h67, 9'd255, ACK_NONE, 1'b0};
        rows[6] = '{FTYPE_ACKREQ, 8'h78, 9'd1, ACK_FIRST, 1'b0};
        repeat (10) @(posedge clk);
        #1;
        check_value("mx_valid", 32'(mx_valid), 32'd0);
        check_value("xbusy", 32'(xbusy), 32'd0);
        check_value("xrdy", 32'(xrdy), 32'd1);
        check_value("xerrcnt", 32'(xerrcnt), 32'd0);
        rst = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end
        $display("Test OK");
        $finish;
    end

endmodule

/* mac_tx_assert.sv */
`timescale 1ns/10ps

module mac_tx_assert (
    input logic              clk,
    input logic              rst,
    input logic              xrdy,
    input logic              cardet,
    input mac_tx_pkg::byte_t mx_data,
    input logic              mx_valid,
    input logic              mx_rdy,
    input logic              xbusy
);

    logic started;

    // set by the first line byte, cleared once the buffer is free again
    always_ff @(posedge clk) begin
        if (rst || !xbusy) begin
            started <= 1'b0;
        end else if (mx_valid) begin
            started <= 1'b1;
        end
    end

    property hold_while_stalled;
        @(posedge clk) disable iff (rst)
        mx_valid && !mx_rdy |=> mx_valid && $stable(mx_data);
    endproperty

    property host_blocked_while_busy;
        @(posedge clk) disable iff (rst)
        xbusy |-> !xrdy;
    endproperty

    property quiet_on_busy_channel;
        @(posedge clk) disable iff (rst)
        cardet && !started |-> !mx_valid;
    endproperty

    assert property (hold_while_stalled)
        else $error("mx_data or mx_valid changed while stalled");
    assert property (host_blocked_while_busy)
        else $error("xrdy high while xbusy");
    assert property (quiet_on_busy_channel)
        else $error("mx_valid raised while cardet high");

endmodule

bind mac_tx_top mac_tx_assert mac_tx_assert_i (
    .clk      (clk),
    .rst      (rst),
    .xrdy     (xrdy),
    .cardet   (cardet),
    .mx_data  (mx_data),
    .mx_valid (mx_valid),
    .mx_rdy   (mx_rdy),
    .xbusy    (xbusy)
);

/* mac_tx_top.sv */
`timescale 1ns/10ps

module mac_tx_top #(
    parameter int                PREAMBLE_LENGTH   = 2,
    parameter mac_tx_pkg::byte_t MAC_ADDR          = 8'h4a,
    parameter int                MAX_PAYLOAD       = 255,
    parameter int                DIFS_TICKS        = 8,
    parameter int                SLOT_TICKS        = 2,
    parameter int                ACK_TIMEOUT_TICKS = 16,
    parameter int                MAX_ATTEMPTS      = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  mac_tx_pkg::byte_t xdata,
    input  logic              xvalid,
    input  logic              xsend,
    output logic              xrdy,
    input  logic              tick,
    input  logic              cardet,
    input  logic              ack_received,
    output mac_tx_pkg::byte_t mx_data,
    output logic              mx_valid,
    input  logic              mx_rdy,
    output logic              xbusy,
    output mac_tx_pkg::byte_t xerrcnt
);

    frame_if fif ();

    // host side builds the frame
    frame_assembler #(
        .PREAMBLE_LENGTH (PREAMBLE_LENGTH),
        .MAC_ADDR        (MAC_ADDR),
        .MAX_PAYLOAD     (MAX_PAYLOAD)
    ) frame_assembler_i (
        .clk    (clk),
        .rst    (rst),
        .xdata  (xdata),
        .xvalid (xvalid),
        .xsend  (xsend),
        .xrdy   (xrdy),
        .wr     (fif.assembler)
    );

    frame_buffer frame_buffer_i (
        .clk (clk),
        .rst (rst),
        .bus (fif.buffer)
    );

    // line side sends it
    xmit_controller #(
        .PREAMBLE_LENGTH   (PREAMBLE_LENGTH),
        .DIFS_TICKS        (DIFS_TICKS),
        .SLOT_TICKS        (SLOT_TICKS),
        .ACK_TIMEOUT_TICKS (ACK_TIMEOUT_TICKS),
        .MAX_ATTEMPTS      (MAX_ATTEMPTS)
    ) xmit_controller_i (
        .clk          (clk),
        .rst          (rst),
        .tick         (tick),
        .cardet       (cardet),
        .ack_received (ack_received),
        .mx_rdy       (mx_rdy),
        .mx_data      (mx_data),
        .mx_valid     (mx_valid),
        .xbusy        (xbusy),
        .xerrcnt      (xerrcnt),
        .rd           (fif.controller)
    );

endmodule

/* xmit_controller.sv */
`timescale 1ns/10ps

module xmit_controller #(
    parameter int PREAMBLE_LENGTH   = 2,
    parameter int DIFS_TICKS        = 8,
    parameter int SLOT_TICKS        = 2,
    parameter int ACK_TIMEOUT_TICKS = 16,
    parameter int MAX_ATTEMPTS      = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              tick,
    input  logic              cardet,
    input  logic              ack_received,
    input  logic              mx_rdy,
    output mac_tx_pkg::byte_t mx_data,
    output logic              mx_valid,
    output logic              xbusy,
    output mac_tx_pkg::byte_t xerrcnt,
    frame_if.controller       rd
);
    import mac_tx_pkg::*;

    typedef enum logic [2:0] {
        IDLE, WAIT_DIFS, WAIT_BACKOFF, FETCH, SEND, SEND_CRC, ACK_WAIT
    } state_t;

    state_t      state;
    logic [15:0] tick_cnt;
    logic [15:0] backoff_lim;
    logic [15:0] draw;
    logic [15:0] lfsr;
    logic [7:0]  attempt_cnt;
    logic        busy_seen;
    buf_addr_t   rd_addr;
    buf_addr_t   sent_cnt;
    logic        rd_vld;
    logic        pf_vld;
    byte_t       pf_data;
    byte_t       crc;
    logic        take;
    logic        out_free;
    logic        load_out;
    logic        pf_next;
    logic        pf_load;
    logic        issue;
    logic        last_take;
    logic        crc_en;

    assign xbusy      = rd.full;
    assign rd.rd_addr = rd_addr;

    // backoff of (k+1) slots, k from 0 to 7
    assign draw = 16'((int'(lfsr[2:0]) + 1) * SLOT_TICKS);

    // output register, prefetch register and one read in flight
    assign take      = mx_valid && mx_rdy;
    assign out_free  = !mx_valid || mx_rdy;
    assign load_out  = (state == SEND) && out_free && (pf_vld || rd_vld);
    assign pf_next   = load_out ? (pf_vld && rd_vld) : (pf_vld || rd_vld);
    assign pf_load   = rd_vld && (pf_vld || !load_out);
    assign issue     = (state == SEND) && !pf_next && (rd_addr < rd.frame_len);
    assign last_take = take && (sent_cnt == rd.frame_len - 1'b1);

    // CRC starts at the destination byte
    assign crc_en = (state == SEND) && take && (sent_cnt >= buf_addr_t'(PREAMBLE_LENGTH + 1));

    crc8_gen crc8_gen_i (
        .clk  (clk),
        .rst  (rst),
        .clr  (state == FETCH),
        .en   (crc_en),
        .data (mx_data),
        .crc  (crc)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= IDLE;
            tick_cnt       <= '0;
            backoff_lim    <= '0;
            lfsr           <= 16'hace1;
            attempt_cnt    <= '0;
            busy_seen      <= 1'b0;
            rd_addr        <= '0;
            sent_cnt       <= '0;
            rd_vld         <= 1'b0;
            pf_vld         <= 1'b0;
            mx_valid       <= 1'b0;
            xerrcnt        <= '0;
            rd.release_buf <= 1'b0;
        end else begin
            lfsr           <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            rd.release_buf <= 1'b0;
            case (state)
                IDLE: begin
                    attempt_cnt <= '0;
                    rd_addr     <= '0;
                    tick_cnt    <= '0;
                    busy_seen   <= 1'b0;
                    // full is still high in the cycle of release
                    if (rd.full && !rd.release_buf) state <= WAIT_DIFS;
                end
                WAIT_DIFS: begin
                    busy_seen <= busy_seen || cardet;
                    if (tick) begin
                        if (tick_cnt == 16'(DIFS_TICKS - 1)) begin
                            tick_cnt <= '0;
                            if (busy_seen || cardet) begin
                                backoff_lim <= draw;
                                state       <= WAIT_BACKOFF;
                            end else begin
                                state <= FETCH;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                WAIT_BACKOFF: begin
                    if (tick) begin
                        if (tick_cnt == backoff_lim - 1'b1) begin
                            tick_cnt <= '0;
                            // channel still busy, draw again
                            if (cardet) backoff_lim <= draw;
                            else state <= FETCH;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                FETCH: begin
                    rd_addr     <= rd_addr + 1'b1;
                    rd_vld      <= 1'b1;
                    pf_vld      <= 1'b0;
                    sent_cnt    <= '0;
                    attempt_cnt <= attempt_cnt + 1'b1;
                    state       <= SEND;
                end
                SEND: begin
                    if (issue) rd_addr <= rd_addr + 1'b1;
                    rd_vld <= issue;
                    pf_vld <= pf_next;
                    if (load_out) mx_valid <= 1'b1;
                    else if (take) mx_valid <= 1'b0;
                    if (take) sent_cnt <= sent_cnt + 1'b1;
                    if (last_take) begin
                        if (rd.frame_ftype == FTYPE_RAW) begin
                            rd.release_buf <= 1'b1;
                            state          <= IDLE;
                        end else begin
                            state <= SEND_CRC;
                        end
                    end
                end
                SEND_CRC: begin
                    // one idle cycle lets the last byte settle into the CRC
                    if (!mx_valid) begin
                        mx_valid <= 1'b1;
                    end else if (mx_rdy) begin
                        mx_valid <= 1'b0;
                        tick_cnt <= '0;
                        if (rd.frame_ftype == FTYPE_ACKREQ) begin
                            state <= ACK_WAIT;
                        end else begin
                            rd.release_buf <= 1'b1;
                            state          <= IDLE;
                        end
                    end
                end
                ACK_WAIT: begin
                    if (ack_received) begin
                        rd.release_buf <= 1'b1;
                        state          <= IDLE;
                    end else if (tick) begin
                        if (tick_cnt == 16'(ACK_TIMEOUT_TICKS - 1)) begin
                            tick_cnt <= '0;
                            if (attempt_cnt == 8'(MAX_ATTEMPTS)) begin
                                xerrcnt        <= xerrcnt + 1'b1;
                                rd.release_buf <= 1'b1;
                                state          <= IDLE;
                            end else begin
                                // resend from the start after a fresh DIFS
                                rd_addr   <= '0;
                                busy_seen <= 1'b0;
                                state     <= WAIT_DIFS;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) mx_data <= pf_vld ? pf_data : rd.rd_data;
        else if (state == SEND_CRC && !mx_valid) mx_data <= crc;
        if (pf_load) pf_data <= rd.rd_data;
    end

endmodule

/* crc8_gen.sv */
`timescale 1ns/10ps

module crc8_gen (
    input  logic              clk,
    input  logic              rst,
    input  logic              clr,
    input  logic              en,
    input  mac_tx_pkg::byte_t data,
    output mac_tx_pkg::byte_t crc
);
    import mac_tx_pkg::*;

    localparam byte_t POLY = 8'h07;

    byte_t crc_next;

    // msb first, eight shift steps per byte
    always_comb begin
        crc_next = crc ^ data;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[7]) crc_next = {crc_next[6:0], 1'b0} ^ POLY;
            else crc_next = {crc_next[6:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            crc <= '0;
        end else if (en) begin
            crc <= crc_next;
        end
    end

endmodule

/* frame_buffer.sv */
`timescale 1ns/10ps

module frame_buffer (
    input  logic     clk,
    input  logic     rst,
    frame_if.buffer  bus
);
    import mac_tx_pkg::*;

    byte_t mem [0:511];

    // byte RAM, registered read
    always_ff @(posedge clk) begin
        if (bus.wr_en) begin
            mem[bus.wr_addr] <= bus.wr_data;
        end
        bus.rd_data <= mem[bus.rd_addr];
    end

    // frame descriptor captured on commit
    always_ff @(posedge clk) begin
        if (bus.commit) begin
            bus.frame_len   <= bus.commit_len;
            bus.frame_ftype <= bus.commit_ftype;
        end
    end

    // one frame at a time
    always_ff @(posedge clk) begin
        if (rst) begin
            bus.full <= 1'b0;
        end else if (bus.commit) begin
            bus.full <= 1'b1;
        end else if (bus.release_buf) begin
            bus.full <= 1'b0;
        end
    end

endmodule

/* frame_assembler.sv */
`timescale 1ns/10ps

module frame_assembler #(
    parameter int                PREAMBLE_LENGTH = 2,
    parameter mac_tx_pkg::byte_t MAC_ADDR        = 8'h4a,
    parameter int                MAX_PAYLOAD     = 255
) (
    input  logic              clk,
    input  logic              rst,
    input  mac_tx_pkg::byte_t xdata,
    input  logic              xvalid,
    input  logic              xsend,
    output logic              xrdy,
    frame_if.assembler        wr
);
    import mac_tx_pkg::*;

    typedef enum logic [2:0] {IDLE, PREAMBLE, SFD, DEST, SRC, TYPE, PAYLOAD, COMMIT} state_t;

    state_t    state;
    buf_addr_t addr;
    buf_addr_t pay_cnt;
    byte_t     dest_q;
    ftype_t    ftype_q;
    logic      take;

    // host bytes only in IDLE (destination), TYPE and PAYLOAD
    assign xrdy = (state == IDLE || state == TYPE || state == PAYLOAD) && !wr.full;
    assign take = xvalid && xrdy;

    assign wr.wr_addr      = addr;
    assign wr.commit       = (state == COMMIT);
    assign wr.commit_len   = buf_addr_t'(PREAMBLE_LENGTH + 1 + HEADER_BYTES) + pay_cnt;
    assign wr.commit_ftype = ftype_q;

    always_comb begin
        wr.wr_en   = 1'b0;
        wr.wr_data = xdata;
        case (state)
            PREAMBLE: begin
                wr.wr_en   = 1'b1;
                wr.wr_data = PREAMBLE_BYTE;
            end
            SFD: begin
                wr.wr_en   = 1'b1;
                wr.wr_data = SFD_BYTE;
            end
            DEST: begin
                wr.wr_en   = 1'b1;
                wr.wr_data = dest_q;
            end
            SRC: begin
                wr.wr_en   = 1'b1;
                wr.wr_data = MAC_ADDR;
            end
            TYPE, PAYLOAD: wr.wr_en = take;
            default: wr.wr_en = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            addr    <= '0;
            pay_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    addr    <= '0;
                    pay_cnt <= '0;
                    if (take) state <= PREAMBLE;
                end
                PREAMBLE: begin
                    addr <= addr + 1'b1;
                    if (addr == buf_addr_t'(PREAMBLE_LENGTH - 1)) state <= SFD;
                end
                SFD: begin
                    addr  <= addr + 1'b1;
                    state <= DEST;
                end
                DEST: begin
                    addr  <= addr + 1'b1;
                    state <= SRC;
                end
                SRC: begin
                    addr  <= addr + 1'b1;
                    state <= TYPE;
                end
                TYPE: begin
                    if (take) begin
                        addr  <= addr + 1'b1;
                        state <= PAYLOAD;
                    end
                end
                PAYLOAD: begin
                    if (take) begin
                        addr    <= addr + 1'b1;
                        pay_cnt <= pay_cnt + 1'b1;
                        // cut the frame at MAX_PAYLOAD even without xsend
                        if (xsend || pay_cnt == buf_addr_t'(MAX_PAYLOAD - 1)) state <= COMMIT;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // destination held until the preamble and SFD are in
    always_ff @(posedge clk) begin
        if (state == IDLE && take) dest_q <= xdata;
        if (state == TYPE && take) ftype_q <= xdata;
    end

endmodule

/* frame_if.sv */
`timescale 1ns/10ps

interface frame_if;
    import mac_tx_pkg::*;

    // write side, from the assembler
    logic      wr_en;
    buf_addr_t wr_addr;
    byte_t     wr_data;
    logic      commit;
    buf_addr_t commit_len;
    ftype_t    commit_ftype;
    logic      full;

    // read side, used by the transmit controller
    buf_addr_t rd_addr;
    byte_t     rd_data;
    buf_addr_t frame_len;
    ftype_t    frame_ftype;
    logic      release_buf;

    modport assembler (
        output wr_en, wr_addr, wr_data, commit, commit_len, commit_ftype,
        input  full
    );

    modport buffer (
        input  wr_en, wr_addr, wr_data, commit, commit_len, commit_ftype, rd_addr, release_buf,
        output full, rd_data, frame_len, frame_ftype
    );

    modport controller (
        output rd_addr, release_buf,
        input  rd_data, frame_len, frame_ftype, full
    );

endinterface

/* mac_tx_pkg.sv */
package mac_tx_pkg;

    // one data byte between host, buffer and line
    typedef logic [7:0] byte_t;

    // frame buffer address, 512 bytes
    typedef logic [8:0] buf_addr_t;

    // frame type field
    typedef logic [7:0] ftype_t;

    // frame type codes
    localparam ftype_t FTYPE_RAW    = 8'h30;
    localparam ftype_t FTYPE_DATA   = 8'h31;
    localparam ftype_t FTYPE_ACKREQ = 8'h32;

    // line framing bytes
    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hd0;

    // destination, source and type, all covered by the CRC
    localparam int HEADER_BYTES = 3;

endpackage
